// ==== core_pkg.sv ====
// ###################################################################
// rv32i core shared types
// opcode, alu function, access size and control state encodings
// ###################################################################

package core_pkg;

  localparam int xlen = 32;  // data and address width

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_op     = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_eq,   // branch compares drive taken only
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_execute,
    st_mem_wait,
    st_writeback,
    st_halt
  } state_e;

endpackage

// ==== lsu_if.sv ====
// ###################################################################
// control to load/store unit request channel
// ###################################################################
`timescale 1ns/1ps

interface lsu_if;

  logic                      start;          // one-cycle request strobe
  logic                      we;
  core_pkg::mem_size_e       size;
  logic                      unsigned_load;
  logic [core_pkg::xlen-1:0] addr;           // byte address
  logic [core_pkg::xlen-1:0] wdata;          // store data, low lanes
  logic [core_pkg::xlen-1:0] rdata;          // extended load data
  logic                      done;           // one-cycle completion pulse

  modport ctrl (
    output start, we, size, unsigned_load, addr, wdata,
    input  rdata, done
  );

  modport lsu (
    input  start, we, size, unsigned_load, addr, wdata,
    output rdata, done
  );

endinterface

// ==== reg_file.sv ====
// ###################################################################
// integer register file, 32 x 32 bit
// two combinational reads, one synchronous write, x0 reads zero
// ###################################################################
`timescale 1ns/1ps

module reg_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [4:0]                rs1_addr,
  input  logic [4:0]                rs2_addr,
  output logic [core_pkg::xlen-1:0] rs1_data,
  output logic [core_pkg::xlen-1:0] rs2_data,
  input  logic [4:0]                rd_addr,
  input  logic [core_pkg::xlen-1:0] rd_data,
  input  logic                      rd_we
);

  logic [core_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_addr != 5'd0) begin  // x0 never written
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

// ==== alu.sv ====
// ###################################################################
// rv32i alu
// arithmetic, logic, shifts, set-less-than and branch compares
// ###################################################################
`timescale 1ns/1ps

module alu (
  input  core_pkg::alu_op_e         op,
  input  logic [core_pkg::xlen-1:0] a,
  input  logic [core_pkg::xlen-1:0] b,
  output logic [core_pkg::xlen-1:0] result,
  output logic                      taken
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = a == b;

  always_comb begin
    case (op)
      core_pkg::alu_add:  result = a + b;
      core_pkg::alu_sub:  result = a - b;
      core_pkg::alu_sll:  result = a << shamt;
      core_pkg::alu_slt:  result = {{(core_pkg::xlen-1){1'b0}}, lt_s};
      core_pkg::alu_sltu: result = {{(core_pkg::xlen-1){1'b0}}, lt_u};
      core_pkg::alu_xor:  result = a ^ b;
      core_pkg::alu_srl:  result = a >> shamt;
      core_pkg::alu_sra:  result = $signed(a) >>> shamt;  // keeps sign bit
      core_pkg::alu_or:   result = a | b;
      core_pkg::alu_and:  result = a & b;
      default:            result = '0;  // compares only
    endcase
  end

  always_comb begin
    case (op)
      core_pkg::alu_eq:  taken = eq;
      core_pkg::alu_ne:  taken = !eq;
      core_pkg::alu_lt:  taken = lt_s;
      core_pkg::alu_ge:  taken = !lt_s;
      core_pkg::alu_ltu: taken = lt_u;
      core_pkg::alu_geu: taken = !lt_u;
      default:           taken = 1'b0;
    endcase
  end

endmodule

// ==== lsu.sv ====
// ###################################################################
// load/store unit
// lane placement, load extension and four-phase req/ack memory port
// ###################################################################
`timescale 1ns/1ps

module lsu (
  input  logic                      clk,
  input  logic                      rst_n,
  lsu_if.lsu                        bus,
  output logic                      mem_req,
  output logic                      mem_we,
  output logic [core_pkg::xlen-1:0] mem_addr,
  output logic [core_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]                mem_be,
  input  logic [core_pkg::xlen-1:0] mem_rdata,
  input  logic                      mem_ack
);

  typedef enum logic [1:0] {
    ls_idle,
    ls_req,
    ls_wait_release,
    ls_done
  } lsu_state_e;

  lsu_state_e                state;
  logic [1:0]                offset;
  logic [1:0]                offset_q;
  core_pkg::mem_size_e       size_q;
  logic                      unsigned_q;
  logic [3:0]                be;
  logic [core_pkg::xlen-1:0] wdata_lane;
  logic [core_pkg::xlen-1:0] rdata_shift;
  logic [core_pkg::xlen-1:0] load_data;
  logic [core_pkg::xlen-1:0] rdata_q;

  assign offset = bus.addr[1:0];

  // store side: enables and data moved to the addressed lanes
  always_comb begin
    case (bus.size)
      core_pkg::size_byte: begin
        be         = 4'b0001 << offset;
        wdata_lane = {24'h0, bus.wdata[7:0]} << {offset, 3'b000};
      end
      core_pkg::size_half: begin
        be         = 4'b0011 << {offset[1], 1'b0};
        wdata_lane = {16'h0, bus.wdata[15:0]} << {offset[1], 4'b0000};
      end
      default: begin
        be         = 4'b1111;
        wdata_lane = bus.wdata;
      end
    endcase
  end

  // load side: addressed lane brought down to bit 0, then extended
  assign rdata_shift = mem_rdata >> {offset_q, 3'b000};

  always_comb begin
    case (size_q)
      core_pkg::size_byte: load_data = {{24{~unsigned_q & rdata_shift[7]}}, rdata_shift[7:0]};
      core_pkg::size_half: load_data = {{16{~unsigned_q & rdata_shift[15]}}, rdata_shift[15:0]};
      default:             load_data = rdata_shift;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ls_idle;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      case (state)
        ls_idle: begin
          if (bus.start) begin
            mem_req <= 1'b1;
            mem_we  <= bus.we;
            state   <= ls_req;
          end
        end
        ls_req: begin
          if (mem_ack) begin  // data valid with ack
            mem_req <= 1'b0;
            state   <= ls_wait_release;
          end
        end
        ls_wait_release: begin
          if (!mem_ack) state <= ls_done;
        end
        ls_done: state <= ls_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ls_idle && bus.start) begin
      mem_addr   <= {bus.addr[31:2], 2'b00};
      mem_wdata  <= wdata_lane;
      mem_be     <= be;
      offset_q   <= offset;
      size_q     <= bus.size;
      unsigned_q <= bus.unsigned_load;
    end
    if (state == ls_req && mem_ack) rdata_q <= load_data;
  end

  assign bus.rdata = rdata_q;
  assign bus.done  = (state == ls_done);

  // request held until the memory has acknowledged it
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack |=> $stable({mem_req, mem_we, mem_addr, mem_wdata, mem_be}));

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    bus.start |-> state == ls_idle);

endmodule

// ==== core_ctrl.sv ====
// ###################################################################
// rv32i control unit
// decode, immediates, pc and the fetch/execute/memory state machine
// ###################################################################
`timescale 1ns/1ps

module core_ctrl #(
  parameter logic [core_pkg::xlen-1:0] RESET_PC = '0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  lsu_if.ctrl                       bus,
  output logic [4:0]                rs1_addr,
  output logic [4:0]                rs2_addr,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] rs2_data,
  output logic [4:0]                rd_addr,
  output logic [core_pkg::xlen-1:0] rd_data,
  output logic                      rd_we,
  output core_pkg::alu_op_e         alu_op,
  output logic [core_pkg::xlen-1:0] alu_a,
  output logic [core_pkg::xlen-1:0] alu_b,
  input  logic [core_pkg::xlen-1:0] alu_result,
  input  logic                      alu_taken,
  output logic                      halted
);

  core_pkg::state_e          state;
  core_pkg::opcode_e         opcode;
  logic [core_pkg::xlen-1:0] pc;
  logic [core_pkg::xlen-1:0] ir;
  logic                      fetch_sent;  // fetch start already issued
  logic [2:0]                funct3;
  logic [core_pkg::xlen-1:0] imm_i;
  logic [core_pkg::xlen-1:0] imm_s;
  logic [core_pkg::xlen-1:0] imm_b;
  logic [core_pkg::xlen-1:0] imm_u;
  logic [core_pkg::xlen-1:0] imm_j;
  logic [core_pkg::xlen-1:0] pc_plus4;
  logic [core_pkg::xlen-1:0] next_pc;
  logic [core_pkg::xlen-1:0] exec_result;
  logic                      wr_rd;
  logic                      halt_req;
  logic                      is_load;
  logic                      is_store;

  function automatic core_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    core_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? core_pkg::alu_sub : core_pkg::alu_add;
      3'b001:  op = core_pkg::alu_sll;
      3'b010:  op = core_pkg::alu_slt;
      3'b011:  op = core_pkg::alu_sltu;
      3'b100:  op = core_pkg::alu_xor;
      3'b101:  op = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
      3'b110:  op = core_pkg::alu_or;
      default: op = core_pkg::alu_and;
    endcase
    return op;
  endfunction

  function automatic core_pkg::alu_op_e branch_op(input logic [2:0] f3);
    core_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = core_pkg::alu_eq;
      3'b001:  op = core_pkg::alu_ne;
      3'b100:  op = core_pkg::alu_lt;
      3'b101:  op = core_pkg::alu_ge;
      3'b110:  op = core_pkg::alu_ltu;
      3'b111:  op = core_pkg::alu_geu;
      default: op = core_pkg::alu_add;  // never taken
    endcase
    return op;
  endfunction

  assign opcode   = core_pkg::opcode_e'(ir[6:0]);
  assign funct3   = ir[14:12];
  assign rs1_addr = ir[19:15];
  assign rs2_addr = ir[24:20];
  assign rd_addr  = ir[11:7];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'h000};
  assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

  assign pc_plus4 = pc + 32'd4;
  assign is_load  = (opcode == core_pkg::op_load);
  assign is_store = (opcode == core_pkg::op_store);

  always_comb begin
    alu_op      = core_pkg::alu_add;
    alu_a       = rs1_data;
    alu_b       = imm_i;
    exec_result = alu_result;
    next_pc     = pc_plus4;
    wr_rd       = 1'b0;
    halt_req    = 1'b0;
    case (opcode)
      core_pkg::op_lui: begin
        exec_result = imm_u;
        wr_rd       = 1'b1;
      end
      core_pkg::op_auipc: begin
        alu_a = pc;
        alu_b = imm_u;
        wr_rd = 1'b1;
      end
      core_pkg::op_jal: begin
        alu_a       = pc;
        alu_b       = imm_j;
        exec_result = pc_plus4;  // link
        next_pc     = alu_result;
        wr_rd       = 1'b1;
      end
      core_pkg::op_jalr: begin
        exec_result = pc_plus4;
        next_pc     = {alu_result[31:1], 1'b0};
        wr_rd       = 1'b1;
      end
      core_pkg::op_branch: begin
        alu_op = branch_op(funct3);
        alu_b  = rs2_data;
        if (alu_taken) next_pc = pc + imm_b;
      end
      core_pkg::op_store: alu_b = imm_s;  // loads keep imm_i
      core_pkg::op_imm: begin
        alu_op = arith_op(funct3, ir[30] && funct3 == 3'b101);
        wr_rd  = 1'b1;
      end
      core_pkg::op_op: begin
        alu_op = arith_op(funct3, ir[30]);
        alu_b  = rs2_data;
        wr_rd  = 1'b1;
      end
      core_pkg::op_system: halt_req = (funct3 == 3'b000 && ir[31:20] == 12'h000);  // ecall
      default: ;
    endcase
  end

  // request fields stay put through mem_wait
  assign bus.start = (state == core_pkg::st_fetch && !fetch_sent) ||
                     (state == core_pkg::st_execute && (is_load || is_store));
  assign bus.we            = (state != core_pkg::st_fetch) && is_store;
  assign bus.unsigned_load = (state != core_pkg::st_fetch) && funct3[2];
  assign bus.addr          = (state == core_pkg::st_fetch) ? pc : alu_result;
  assign bus.wdata         = rs2_data;

  always_comb begin
    if (state == core_pkg::st_fetch) begin
      bus.size = core_pkg::size_word;
    end else begin
      case (funct3[1:0])
        2'b00:   bus.size = core_pkg::size_byte;
        2'b01:   bus.size = core_pkg::size_half;
        default: bus.size = core_pkg::size_word;
      endcase
    end
  end

  assign rd_we   = (state == core_pkg::st_execute && wr_rd) || state == core_pkg::st_writeback;
  assign rd_data = (state == core_pkg::st_writeback) ? bus.rdata : exec_result;
  assign halted  = (state == core_pkg::st_halt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= core_pkg::st_fetch;
      pc         <= RESET_PC;
      fetch_sent <= 1'b0;
    end else begin
      case (state)
        core_pkg::st_fetch: begin
          if (bus.done) begin
            fetch_sent <= 1'b0;
            state      <= core_pkg::st_execute;
          end else if (!fetch_sent) begin
            fetch_sent <= 1'b1;
          end
        end
        core_pkg::st_execute: begin
          if (halt_req) begin
            state <= core_pkg::st_halt;  // pc left on the ecall
          end else begin
            pc    <= next_pc;
            state <= (is_load || is_store) ? core_pkg::st_mem_wait : core_pkg::st_fetch;
          end
        end
        core_pkg::st_mem_wait: begin
          if (bus.done) state <= is_load ? core_pkg::st_writeback : core_pkg::st_fetch;
        end
        core_pkg::st_writeback: state <= core_pkg::st_fetch;
        default: state <= core_pkg::st_halt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == core_pkg::st_fetch && bus.done) ir <= bus.rdata;
  end

  // load writeback only right after its memory access
  a_rd_we_state: assert property (@(posedge clk) disable iff (!rst_n)
    rd_we |-> state == core_pkg::st_execute ||
              (state == core_pkg::st_writeback && $past(state) == core_pkg::st_mem_wait));

endmodule

// ==== rv_core_top.sv ====
// ###################################################################
// rv32i core top level
// control unit, register file, alu and load/store unit on one port
// ###################################################################
`timescale 1ns/1ps

module rv_core_top #(
  parameter logic [core_pkg::xlen-1:0] RESET_PC = '0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic                      mem_req,
  output logic                      mem_we,
  output logic [core_pkg::xlen-1:0] mem_addr,
  output logic [core_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]                mem_be,
  input  logic [core_pkg::xlen-1:0] mem_rdata,
  input  logic                      mem_ack,
  output logic                      halted
);

  logic [4:0]                rs1_addr;
  logic [4:0]                rs2_addr;
  logic [4:0]                rd_addr;
  logic [core_pkg::xlen-1:0] rs1_data;
  logic [core_pkg::xlen-1:0] rs2_data;
  logic [core_pkg::xlen-1:0] rd_data;
  logic                      rd_we;
  core_pkg::alu_op_e         alu_op;
  logic [core_pkg::xlen-1:0] alu_a;
  logic [core_pkg::xlen-1:0] alu_b;
  logic [core_pkg::xlen-1:0] alu_result;
  logic                      alu_taken;

  lsu_if lsu_bus ();

  core_ctrl #(.RESET_PC(RESET_PC)) i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (lsu_bus.ctrl),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_we      (rd_we),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_result (alu_result),
    .alu_taken  (alu_taken),
    .halted     (halted)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_we    (rd_we)
  );

  alu i_alu (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .taken  (alu_taken)
  );

  lsu i_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (lsu_bus.lsu),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_be    (mem_be),
    .mem_rdata (mem_rdata),
    .mem_ack   (mem_ack)
  );

endmodule

// ==== tb_clk_gen.sv ====
// ######################################################################
// testbench clock and reset, 4 ns period, reset low for two cycles
// ######################################################################
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;  // released off the edge
  end

endmodule

// ==== tb_top.sv ====
// ######################################################################
// rv32i core testbench
// preloaded memory model with random ack delay, program table, checks
// ######################################################################
`timescale 1ns/1ps

module tb_top;

  logic        clk;
  logic        rst_n;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_be;
  logic [31:0] mem_rdata;
  logic        mem_ack;
  logic        halted;

  logic [31:0] mem [256];
  logic [31:0] tab_addr [$];
  logic [31:0] tab_word [$];
  logic [31:0] tab_exp [$];
  bit          tab_chk [$];
  logic [31:0] pc_acc;
  logic        req_q;
  logic        halt_q;
  int          halt_count;

  tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  rv_core_top #(.RESET_PC(32'h0)) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_be    (mem_be),
    .mem_rdata (mem_rdata),
    .mem_ack   (mem_ack),
    .halted    (halted)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // RV32I instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] word);
    tab_addr.push_back(pc_acc);
    tab_word.push_back(word);
    tab_exp.push_back(32'h0);
    tab_chk.push_back(1'b0);
    pc_acc = pc_acc + 32'd4;
  endtask

  task automatic slot(input logic [31:0] addr, input logic [31:0] prior, input logic [31:0] exp);
    tab_addr.push_back(addr);
    tab_word.push_back(prior);
    tab_exp.push_back(exp);
    tab_chk.push_back(1'b1);
  endtask

  // sw rs into a fresh result slot
  task automatic store_result(input logic [4:0] rs, input logic [31:0] addr,
                              input logic [31:0] exp);
    put(s_type(3'd2, rs, 5'd0, addr));
    slot(addr, 32'hDEADBEEF, exp);
  endtask

  // taken branch skips the marker store
  task automatic branch_pair(input logic [2:0] f3, input logic [4:0] ra, input logic [4:0] rb,
                             input logic [31:0] addr, input bit taken);
    put(b_type(f3, ra, rb, 32'd8));
    put(s_type(3'd2, 5'd24, 5'd0, addr));
    slot(addr, 32'hDEADBEEF, taken ? 32'hDEADBEEF : 32'h00000077);
  endtask

  task automatic build_table();
    logic [31:0] q;
    pc_acc = 32'h0;
    put(i_type(7'b0010011, 3'd0, 5'd1, 5'd0, 32'hFFFFFFFB));  // x1 = -5
    put(i_type(7'b0010011, 3'd0, 5'd2, 5'd0, 32'd3));
    put(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    store_result(5'd3, 32'h200, 32'hFFFFFFFE);
    put(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd4));               // 3 - (-5)
    store_result(5'd4, 32'h204, 32'h00000008);
    put(r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd5));
    store_result(5'd5, 32'h208, 32'hFFFFFFF8);
    put(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd6));
    store_result(5'd6, 32'h20C, 32'hFFFFFFFB);
    put(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd7));
    store_result(5'd7, 32'h210, 32'h00000003);
    put(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd8));
    store_result(5'd8, 32'h214, 32'h00000001);
    put(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd9));
    store_result(5'd9, 32'h218, 32'h00000000);
    put(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd10));
    store_result(5'd10, 32'h21C, 32'hFFFFFFFF);
    put(r_type(7'h00, 5'd2, 5'd1, 3'd5, 5'd11));
    store_result(5'd11, 32'h220, 32'h1FFFFFFF);
    put(r_type(7'h00, 5'd2, 5'd1, 3'd1, 5'd12));
    store_result(5'd12, 32'h224, 32'hFFFFFFD8);
    put(i_type(7'b0010011, 3'd5, 5'd13, 5'd1, 32'h401));       // srai by 1
    store_result(5'd13, 32'h228, 32'hFFFFFFFD);
    put(u_type(7'b0110111, 5'd14, 20'h12345));
    store_result(5'd14, 32'h22C, 32'h12345000);
    q = pc_acc;
    put(u_type(7'b0010111, 5'd15, 20'h00001));
    store_result(5'd15, 32'h230, q + 32'h1000);
    // sub-word stores at every lane
    put(i_type(7'b0010011, 3'd0, 5'd16, 5'd0, 32'h0AB));
    put(u_type(7'b0110111, 5'd17, 20'h00001));
    put(i_type(7'b0010011, 3'd0, 5'd17, 5'd17, 32'h234));
    put(s_type(3'd0, 5'd16, 5'd0, 32'h235));
    slot(32'h234, 32'h11223344, 32'h1122AB44);
    put(s_type(3'd0, 5'd16, 5'd0, 32'h23B));
    slot(32'h238, 32'h55667788, 32'hAB667788);
    put(s_type(3'd0, 5'd16, 5'd0, 32'h246));
    slot(32'h244, 32'hFFFFFFFF, 32'hFFABFFFF);
    put(s_type(3'd0, 5'd16, 5'd0, 32'h248));
    slot(32'h248, 32'h00000000, 32'h000000AB);
    put(s_type(3'd1, 5'd17, 5'd0, 32'h23E));
    slot(32'h23C, 32'hCCDDEEFF, 32'h1234EEFF);
    put(s_type(3'd1, 5'd17, 5'd0, 32'h240));
    slot(32'h240, 32'h99999999, 32'h99991234);
    // loads from a fixed pattern word
    slot(32'h24C, 32'h80008080, 32'h80008080);
    put(i_type(7'b0000011, 3'd0, 5'd18, 5'd0, 32'h24C));
    store_result(5'd18, 32'h250, 32'hFFFFFF80);
    put(i_type(7'b0000011, 3'd4, 5'd19, 5'd0, 32'h24D));
    store_result(5'd19, 32'h254, 32'h00000080);
    put(i_type(7'b0000011, 3'd1, 5'd20, 5'd0, 32'h24E));
    store_result(5'd20, 32'h258, 32'hFFFF8000);
    put(i_type(7'b0000011, 3'd5, 5'd21, 5'd0, 32'h24E));
    store_result(5'd21, 32'h25C, 32'h00008000);
    put(i_type(7'b0000011, 3'd1, 5'd22, 5'd0, 32'h24C));
    store_result(5'd22, 32'h260, 32'hFFFF8080);
    put(i_type(7'b0000011, 3'd2, 5'd23, 5'd0, 32'h24C));
    store_result(5'd23, 32'h264, 32'h80008080);
    // branches on x1 = -5 and x2 = 3
    put(i_type(7'b0010011, 3'd0, 5'd24, 5'd0, 32'h077));
    branch_pair(3'd0, 5'd2, 5'd2, 32'h268, 1'b1);
    branch_pair(3'd0, 5'd1, 5'd2, 32'h26C, 1'b0);
    branch_pair(3'd1, 5'd1, 5'd2, 32'h270, 1'b1);
    branch_pair(3'd1, 5'd2, 5'd2, 32'h274, 1'b0);
    branch_pair(3'd4, 5'd1, 5'd2, 32'h278, 1'b1);
    branch_pair(3'd4, 5'd2, 5'd1, 32'h27C, 1'b0);
    branch_pair(3'd5, 5'd2, 5'd1, 32'h280, 1'b1);
    branch_pair(3'd5, 5'd1, 5'd2, 32'h284, 1'b0);
    branch_pair(3'd6, 5'd2, 5'd1, 32'h288, 1'b1);
    branch_pair(3'd6, 5'd1, 5'd2, 32'h28C, 1'b0);
    branch_pair(3'd7, 5'd1, 5'd2, 32'h290, 1'b1);
    branch_pair(3'd7, 5'd2, 5'd1, 32'h294, 1'b0);
    // jal over one store
    q = pc_acc;
    put(j_type(5'd25, 32'd8));
    put(s_type(3'd2, 5'd24, 5'd0, 32'h298));
    slot(32'h298, 32'hDEADBEEF, 32'hDEADBEEF);
    store_result(5'd25, 32'h29C, q + 32'd4);
    // jalr to an odd target drops bit 0
    q = pc_acc;
    put(u_type(7'b0010111, 5'd26, 20'h00000));
    put(i_type(7'b1100111, 3'd0, 5'd27, 5'd26, 32'd13));
    put(s_type(3'd2, 5'd24, 5'd0, 32'h2A0));
    slot(32'h2A0, 32'hDEADBEEF, 32'hDEADBEEF);
    store_result(5'd27, 32'h2A4, q + 32'd8);
    put(32'h00000073);  // ecall
  endtask

  // memory side of the four-phase handshake
  initial begin
    int unsigned delay;
    void'($urandom(7));
    forever begin
      @(posedge clk);
      if (mem_req && !mem_ack) begin
        delay = $urandom % 6;
        repeat (delay) @(posedge clk);
        #1;
        if (mem_we) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_be[b]) mem[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
          end
        end else begin
          mem_rdata = mem[mem_addr[9:2]];
        end
        mem_ack = 1'b1;
        do @(posedge clk); while (mem_req);
        #1 mem_ack = 1'b0;
      end
    end
  end

  // request rise and halt pulse monitors
  always @(posedge clk) begin
    if (rst_n) begin
      if (mem_req && !req_q) check("mem_ack at mem_req rise", {31'h0, mem_ack}, 32'h0);
      if (halted && !halt_q) halt_count++;
    end
    req_q  = mem_req;
    halt_q = halted;
  end

  initial begin
    int unsigned limit;
    mem_ack    = 1'b0;
    mem_rdata  = 32'h0;
    req_q      = 1'b0;
    halt_q     = 1'b0;
    halt_count = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5A000000 | (i << 2);  // address-tagged fill
    end
    build_table();
    for (int i = 0; i < tab_addr.size(); i++) begin
      mem[tab_addr[i][9:2]] = tab_word[i];
    end
    limit = tab_addr.size() * 64;
    fork
      begin
        repeat (limit) @(posedge clk);
        $display("Timeout: core did not halt within %0d cycles", limit);
        $display("*** FAILED ***");
        $fatal(1);
      end
    join_none
    wait (rst_n === 1'b1);
    while (halted !== 1'b1) @(posedge clk);
    repeat (4) @(posedge clk);
    check("halted", {31'h0, halted}, 32'h1);
    check("halt_count", halt_count, 32'h1);
    for (int i = 0; i < tab_addr.size(); i++) begin
      if (tab_chk[i]) check($sformatf("mem[0x%03h]", tab_addr[i]), mem[tab_addr[i][9:2]],
                            tab_exp[i]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
core_pkg.sv
lsu_if.sv
reg_file.sv
alu.sv
lsu.sv
core_ctrl.sv
rv_core_top.sv
tb_clk_gen.sv
tb_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_top
FILELIST := tb.f
PASS_MSG := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
